/* include/dma_config.svh */
// widths, depths and page size of the dma backend
`ifndef DMA_CONFIG_SVH
`define DMA_CONFIG_SVH

// --------------------------------------------------
// bus geometry
// --------------------------------------------------
`define DMA_ADDR_WIDTH 32
// bytes per beat, data width follows from it
`define DMA_DATA_BYTES 4
`define DMA_DATA_WIDTH (8 * `DMA_DATA_BYTES)
// burst length field holds beats minus one
`define DMA_LEN_WIDTH 4
`define DMA_MAX_BEATS 16
// no burst may cross this boundary
`define DMA_PAGE_BYTES 4096

// --------------------------------------------------
// buffering
// --------------------------------------------------
`define DMA_REQ_DEPTH 4
`define DMA_BUFFER_DEPTH 8
`define DMA_AX_DEPTH 4

`endif

/* source/dma_pkg.sv */
// dma types: transfer request, descriptors, bus bundles and state enums
`include "dma_config.svh"

package dma_pkg;

    typedef logic [`DMA_ADDR_WIDTH-1:0] addr_t;
    typedef logic [`DMA_LEN_WIDTH-1:0]  len_t;
    typedef logic [`DMA_DATA_WIDTH-1:0] data_t;
    typedef logic [31:0]                count_t;

    // one contiguous word-aligned transfer
    typedef struct packed {
        addr_t  src;
        addr_t  dst;
        count_t num_bytes;
    } burst_req_t;

    // burst descriptor from reshaper to mover
    typedef struct packed {
        addr_t addr;
        len_t  len;
        logic  last;    // final burst of its request
    } ax_desc_t;

    // address channel payload, shared by ar and aw
    typedef struct packed {
        addr_t addr;
        len_t  len;
    } dma_ax_t;

    // data beat, shared by r and w
    typedef struct packed {
        data_t data;
        logic  last;
    } dma_beat_t;

    // --------------------------------------------------
    // master port bundles
    // --------------------------------------------------
    typedef struct packed {
        dma_ax_t   ar;
        logic      ar_valid;
        dma_ax_t   aw;
        logic      aw_valid;
        dma_beat_t w;
        logic      w_valid;
        logic      r_ready;
        logic      b_ready;
    } dma_axi_req_t;

    typedef struct packed {
        logic      ar_ready;
        logic      aw_ready;
        logic      w_ready;
        dma_beat_t r;
        logic      r_valid;
        logic      b_valid;
    } dma_axi_rsp_t;

    typedef enum logic {IDLE, SPLIT} reshaper_state_e;
    typedef enum logic {W_ADDR, W_DATA} write_state_e;

endpackage

/* source/dma_queue.sv */
// synchronous fifo with fill count, push and pop in one cycle allowed
`timescale 1ns/1ps

module dma_queue #(
    parameter int unsigned WIDTH = 8,
    parameter int unsigned DEPTH = 4
) (
    input  logic             clk_i,
    input  logic             rst_ni,
    input  logic             push_i,
    input  logic [WIDTH-1:0] data_i,
    input  logic             pop_i,
    output logic [WIDTH-1:0] data_o,
    output logic             full_o,
    output logic             empty_o
);
    localparam int unsigned PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
    localparam int unsigned CNT_W = $clog2(DEPTH + 1);

    logic [WIDTH-1:0] mem_q [DEPTH];
    logic [PTR_W-1:0] rd_ptr_q;
    logic [PTR_W-1:0] wr_ptr_q;
    logic [CNT_W-1:0] count_q;
    logic             do_push;
    logic             do_pop;

    // requests on a full or empty queue are ignored
    assign do_push = push_i && !full_o;
    assign do_pop  = pop_i && !empty_o;

    assign full_o  = (count_q == CNT_W'(DEPTH));
    assign empty_o = (count_q == '0);
    assign data_o  = mem_q[rd_ptr_q];

    always_ff @(posedge clk_i) begin
        if (rst_ni) begin
            rd_ptr_q <= '0;
            wr_ptr_q <= '0;
            count_q  <= '0;
        end else begin
            // pointers wrap explicitly, depth need not be a power of two
            if (do_push) begin
                wr_ptr_q <= (wr_ptr_q == PTR_W'(DEPTH - 1)) ? '0 : wr_ptr_q + 1'b1;
            end
            if (do_pop) begin
                rd_ptr_q <= (rd_ptr_q == PTR_W'(DEPTH - 1)) ? '0 : rd_ptr_q + 1'b1;
            end
            count_q <= count_q + CNT_W'(do_push) - CNT_W'(do_pop);
        end
    end

    // storage
    always_ff @(posedge clk_i) begin
        if (do_push) begin
            mem_q[wr_ptr_q] <= data_i;
        end
    end

endmodule

/* source/dma_burst_reshaper.sv */
// burst reshaper: cuts requests into page-safe, length-limited bursts
`timescale 1ns/1ps
`include "dma_config.svh"

module dma_burst_reshaper (
    input  logic                 clk_i,
    input  logic                 rst_ni,
    input  dma_pkg::burst_req_t  burst_req_i,
    input  logic                 req_valid_i,
    output logic                 req_pop_o,
    output dma_pkg::ax_desc_t    read_desc_o,
    output logic                 read_valid_o,
    input  logic                 read_ready_i,
    output dma_pkg::ax_desc_t    write_desc_o,
    output logic                 write_valid_o,
    input  logic                 write_ready_i,
    output logic                 busy_o
);
    localparam int unsigned MAX_BURST_BYTES = `DMA_MAX_BEATS * `DMA_DATA_BYTES;
    localparam int unsigned PAGE_BITS = $clog2(`DMA_PAGE_BYTES);
    localparam int unsigned BEAT_SHIFT = $clog2(`DMA_DATA_BYTES);

    dma_pkg::reshaper_state_e state_q;
    dma_pkg::addr_t           src_q;
    dma_pkg::addr_t           dst_q;
    dma_pkg::count_t          remaining_q;
    logic                     read_taken_q;
    logic                     write_taken_q;

    dma_pkg::count_t src_to_page;
    dma_pkg::count_t dst_to_page;
    dma_pkg::count_t step_bytes;
    dma_pkg::count_t step_beats;
    logic            last_step;
    logic            read_done;
    logic            write_done;

    // --------------------------------------------------
    // step size
    // --------------------------------------------------
    // distance to the next page boundary on each side
    assign src_to_page = 32'(`DMA_PAGE_BYTES) - 32'(src_q[PAGE_BITS-1:0]);
    assign dst_to_page = 32'(`DMA_PAGE_BYTES) - 32'(dst_q[PAGE_BITS-1:0]);

    // smallest of remaining, both page limits and max burst
    always_comb begin
        step_bytes = remaining_q;
        if (src_to_page < step_bytes) begin
            step_bytes = src_to_page;
        end
        if (dst_to_page < step_bytes) begin
            step_bytes = dst_to_page;
        end
        if (32'(MAX_BURST_BYTES) < step_bytes) begin
            step_bytes = 32'(MAX_BURST_BYTES);
        end
    end

    assign step_beats = step_bytes >> BEAT_SHIFT;
    assign last_step  = (step_bytes == remaining_q);

    // --------------------------------------------------
    // descriptor outputs
    // --------------------------------------------------
    assign read_desc_o.addr  = src_q;
    assign read_desc_o.len   = `DMA_LEN_WIDTH'(step_beats - 1);
    assign read_desc_o.last  = last_step;
    assign write_desc_o.addr = dst_q;
    assign write_desc_o.len  = `DMA_LEN_WIDTH'(step_beats - 1);
    assign write_desc_o.last = last_step;

    // each channel drops valid once its descriptor is taken
    assign read_valid_o  = (state_q == dma_pkg::SPLIT) && !read_taken_q;
    assign write_valid_o = (state_q == dma_pkg::SPLIT) && !write_taken_q;
    assign read_done     = read_taken_q || (read_valid_o && read_ready_i);
    assign write_done    = write_taken_q || (write_valid_o && write_ready_i);

    // head popped whenever idle, zero-count requests vanish here
    assign req_pop_o = (state_q == dma_pkg::IDLE) && req_valid_i;
    assign busy_o    = (state_q == dma_pkg::SPLIT);

    // --------------------------------------------------
    // state machine
    // --------------------------------------------------
    always_ff @(posedge clk_i) begin
        if (rst_ni) begin
            state_q       <= dma_pkg::IDLE;
            src_q         <= '0;
            dst_q         <= '0;
            remaining_q   <= '0;
            read_taken_q  <= 1'b0;
            write_taken_q <= 1'b0;
        end else begin
            case (state_q)
                dma_pkg::IDLE: begin
                    if (req_pop_o && (burst_req_i.num_bytes != '0)) begin
                        src_q       <= burst_req_i.src;
                        dst_q       <= burst_req_i.dst;
                        remaining_q <= burst_req_i.num_bytes;
                        state_q     <= dma_pkg::SPLIT;
                    end
                end
                dma_pkg::SPLIT: begin
                    if (read_done && write_done) begin
                        // both sides taken, move to the next step
                        src_q         <= src_q + `DMA_ADDR_WIDTH'(step_bytes);
                        dst_q         <= dst_q + `DMA_ADDR_WIDTH'(step_bytes);
                        remaining_q   <= remaining_q - step_bytes;
                        read_taken_q  <= 1'b0;
                        write_taken_q <= 1'b0;
                        if (last_step) begin
                            state_q <= dma_pkg::IDLE;
                        end
                    end else begin
                        read_taken_q  <= read_done;
                        write_taken_q <= write_done;
                    end
                end
                default: state_q <= dma_pkg::IDLE;
            endcase
        end
    end

endmodule

/* source/dma_data_mover.sv */
// data mover: ar/aw issue, beat buffer, w streaming, response tracking
`timescale 1ns/1ps
`include "dma_config.svh"

module dma_data_mover (
    input  logic                  clk_i,
    input  logic                  rst_ni,
    input  dma_pkg::ax_desc_t     read_desc_i,
    input  logic                  read_valid_i,
    output logic                  read_ready_o,
    input  dma_pkg::ax_desc_t     write_desc_i,
    input  logic                  write_valid_i,
    output logic                  write_ready_o,
    output dma_pkg::dma_axi_req_t axi_req_o,
    input  dma_pkg::dma_axi_rsp_t axi_rsp_i,
    input  logic                  req_empty_i,
    input  logic                  reshaper_busy_i,
    output logic                  trans_complete_o,
    output logic                  mover_idle_o
);
    dma_pkg::ax_desc_t    ar_head;
    logic                 ar_full;
    logic                 ar_empty;
    dma_pkg::ax_desc_t    aw_head;
    logic                 aw_full;
    logic                 aw_empty;
    dma_pkg::dma_beat_t   buf_head;
    logic                 buf_full;
    logic                 buf_empty;
    logic                 last_head;
    logic                 last_full;
    logic                 last_empty;

    dma_pkg::write_state_e wr_state_q;
    dma_pkg::len_t         beat_len_q;
    dma_pkg::len_t         beat_cnt_q;

    logic ar_fire;
    logic r_fire;
    logic aw_fire;
    logic w_fire;
    logic b_fire;

    // --------------------------------------------------
    // read side
    // --------------------------------------------------
    assign read_ready_o = !ar_full;
    assign ar_fire      = axi_req_o.ar_valid && axi_rsp_i.ar_ready;
    assign r_fire       = axi_rsp_i.r_valid && axi_req_o.r_ready;

    dma_queue #(.WIDTH($bits(dma_pkg::ax_desc_t)), .DEPTH(`DMA_AX_DEPTH)) i_ar_queue (
        .clk_i(clk_i), .rst_ni(rst_ni),
        .push_i(read_valid_i), .data_i(read_desc_i), .pop_i(ar_fire),
        .data_o(ar_head), .full_o(ar_full), .empty_o(ar_empty)
    );

    // r beats land here until the write side drains them
    dma_queue #(.WIDTH($bits(dma_pkg::dma_beat_t)), .DEPTH(`DMA_BUFFER_DEPTH)) i_beat_buffer (
        .clk_i(clk_i), .rst_ni(rst_ni),
        .push_i(r_fire), .data_i(axi_rsp_i.r), .pop_i(w_fire),
        .data_o(buf_head), .full_o(buf_full), .empty_o(buf_empty)
    );

    // --------------------------------------------------
    // write side
    // --------------------------------------------------
    assign write_ready_o = !aw_full;
    assign aw_fire       = axi_req_o.aw_valid && axi_rsp_i.aw_ready;
    assign w_fire        = axi_req_o.w_valid && axi_rsp_i.w_ready;
    assign b_fire        = axi_rsp_i.b_valid && axi_req_o.b_ready;

    dma_queue #(.WIDTH($bits(dma_pkg::ax_desc_t)), .DEPTH(`DMA_AX_DEPTH)) i_aw_queue (
        .clk_i(clk_i), .rst_ni(rst_ni),
        .push_i(write_valid_i), .data_i(write_desc_i), .pop_i(aw_fire),
        .data_o(aw_head), .full_o(aw_full), .empty_o(aw_empty)
    );

    // one entry per burst with aw sent and b still due
    dma_queue #(.WIDTH(1), .DEPTH(`DMA_AX_DEPTH)) i_last_queue (
        .clk_i(clk_i), .rst_ni(rst_ni),
        .push_i(aw_fire), .data_i(aw_head.last), .pop_i(b_fire),
        .data_o(last_head), .full_o(last_full), .empty_o(last_empty)
    );

    // aw waits for room to track its response
    always_comb begin
        axi_req_o.ar.addr = ar_head.addr;
        axi_req_o.ar.len  = ar_head.len;
        axi_req_o.ar_valid = !ar_empty;
        axi_req_o.aw.addr = aw_head.addr;
        axi_req_o.aw.len  = aw_head.len;
        axi_req_o.aw_valid = (wr_state_q == dma_pkg::W_ADDR) && !aw_empty && !last_full;
        axi_req_o.w.data  = buf_head.data;
        axi_req_o.w.last  = (beat_cnt_q == beat_len_q);
        axi_req_o.w_valid = (wr_state_q == dma_pkg::W_DATA) && !buf_empty;
        axi_req_o.r_ready = !buf_full;
        axi_req_o.b_ready = 1'b1;
    end

    // write fsm, one aw then its beats
    always_ff @(posedge clk_i) begin
        if (rst_ni) begin
            wr_state_q <= dma_pkg::W_ADDR;
            beat_len_q <= '0;
            beat_cnt_q <= '0;
        end else if (wr_state_q == dma_pkg::W_ADDR) begin
            if (aw_fire) begin
                beat_len_q <= aw_head.len;
                beat_cnt_q <= '0;
                wr_state_q <= dma_pkg::W_DATA;
            end
        end else if (w_fire) begin
            beat_cnt_q <= beat_cnt_q + 1'b1;
            if (axi_req_o.w.last) begin
                wr_state_q <= dma_pkg::W_ADDR;
            end
        end
    end

    // --------------------------------------------------
    // completion and idle
    // --------------------------------------------------
    assign trans_complete_o = b_fire && !last_empty && last_head;

    assign mover_idle_o = req_empty_i && !reshaper_busy_i && ar_empty && buf_empty
                          && aw_empty && last_empty && (wr_state_q == dma_pkg::W_ADDR);

endmodule

/* source/dma_backend.sv */
// dma backend top: request queue, burst reshaper and data mover
`timescale 1ns/1ps
`include "dma_config.svh"

module dma_backend (
    input  logic                  clk_i,
    input  logic                  rst_ni,
    input  dma_pkg::burst_req_t   burst_req_i,
    input  logic                  valid_i,
    output logic                  ready_o,
    output dma_pkg::dma_axi_req_t axi_req_o,
    input  dma_pkg::dma_axi_rsp_t axi_rsp_i,
    output logic                  backend_idle_o,
    output logic                  trans_complete_o
);
    // --------------------------------------------------
    // request queue
    // --------------------------------------------------
    dma_pkg::burst_req_t req_head;
    logic                req_full;
    logic                req_empty;
    logic                req_pop;

    // push beyond full is dropped inside the queue, ready_o tells the source
    dma_queue #(.WIDTH($bits(dma_pkg::burst_req_t)), .DEPTH(`DMA_REQ_DEPTH)) i_request_queue (
        .clk_i(clk_i), .rst_ni(rst_ni),
        .push_i(valid_i), .data_i(burst_req_i), .pop_i(req_pop),
        .data_o(req_head), .full_o(req_full), .empty_o(req_empty)
    );

    assign ready_o = !req_full;

    // --------------------------------------------------
    // reshaper to mover
    // --------------------------------------------------
    dma_pkg::ax_desc_t read_desc;
    dma_pkg::ax_desc_t write_desc;
    logic              read_valid;
    logic              read_ready;
    logic              write_valid;
    logic              write_ready;
    logic              reshaper_busy;

    dma_burst_reshaper i_burst_reshaper (
        .clk_i(clk_i), .rst_ni(rst_ni),
        .burst_req_i(req_head), .req_valid_i(!req_empty), .req_pop_o(req_pop),
        .read_desc_o(read_desc), .read_valid_o(read_valid), .read_ready_i(read_ready),
        .write_desc_o(write_desc), .write_valid_o(write_valid), .write_ready_i(write_ready),
        .busy_o(reshaper_busy)
    );

    // idle gathered inside the mover
    dma_data_mover i_data_mover (
        .clk_i(clk_i), .rst_ni(rst_ni),
        .read_desc_i(read_desc), .read_valid_i(read_valid), .read_ready_o(read_ready),
        .write_desc_i(write_desc), .write_valid_i(write_valid), .write_ready_o(write_ready),
        .axi_req_o(axi_req_o), .axi_rsp_i(axi_rsp_i),
        .req_empty_i(req_empty), .reshaper_busy_i(reshaper_busy),
        .trans_complete_o(trans_complete_o), .mover_idle_o(backend_idle_o)
    );

endmodule

/* bench/dma_mem_model.sv */
// memory slave for the dma master port with lfsr-driven ready stalls
`timescale 1ns/1ps

module dma_mem_model (
    input  logic                  clk_i,
    input  logic                  rst_ni,
    input  logic                  stall_en_i,
    input  logic                  hold_ar_i,
    input  dma_pkg::dma_axi_req_t axi_req_i,
    output dma_pkg::dma_axi_rsp_t axi_rsp_o
);
    logic [31:0] mem [16384];
    logic [31:0] lfsr_q;
    logic        stall_ar_q;
    logic        stall_w_q;
    logic        rd_busy_q;
    logic [13:0] rd_addr_q;
    logic [3:0]  rd_left_q;
    logic        wr_busy_q;
    logic [13:0] wr_addr_q;
    logic        b_pend_q;

    // galois lfsr, one step per stall bit
    function automatic logic [31:0] lfsr_step(input logic [31:0] s);
        return s[0] ? ((s >> 1) ^ 32'h80200003) : (s >> 1);
    endfunction

    // fill pattern from the full word address
    initial begin
        for (int i = 0; i < 16384; i++) begin
            mem[i] = (32'(i) * 32'h9e3779b1) ^ 32'h5a5a0000;
        end
    end

    assign axi_rsp_o.ar_ready = !rd_busy_q && !hold_ar_i && !stall_ar_q;
    assign axi_rsp_o.r.data   = mem[rd_addr_q];
    assign axi_rsp_o.r.last   = (rd_left_q == '0);
    assign axi_rsp_o.r_valid  = rd_busy_q;
    assign axi_rsp_o.aw_ready = !wr_busy_q && !b_pend_q;
    assign axi_rsp_o.w_ready  = wr_busy_q && !stall_w_q;
    assign axi_rsp_o.b_valid  = b_pend_q;

    always @(posedge clk_i) begin
        logic [31:0] s;
        if (rst_ni) begin
            lfsr_q     <= 32'd68947;
            stall_ar_q <= 1'b0;
            stall_w_q  <= 1'b0;
            rd_busy_q  <= 1'b0;
            rd_addr_q  <= '0;
            rd_left_q  <= '0;
            wr_busy_q  <= 1'b0;
            wr_addr_q  <= '0;
            b_pend_q   <= 1'b0;
        end else begin
            // --------------------------------------------------
            // stall draws
            // --------------------------------------------------
            if (stall_en_i) begin
                s = lfsr_step(lfsr_q);
                stall_ar_q <= s[0];
                s = lfsr_step(s);
                stall_w_q <= s[0];
                lfsr_q <= s;
            end else begin
                stall_ar_q <= 1'b0;
                stall_w_q  <= 1'b0;
            end
            // one read burst at a time
            if (axi_req_i.ar_valid && axi_rsp_o.ar_ready) begin
                rd_busy_q <= 1'b1;
                rd_addr_q <= axi_req_i.ar.addr[15:2];
                rd_left_q <= axi_req_i.ar.len;
            end else if (rd_busy_q && axi_req_i.r_ready) begin
                rd_addr_q <= rd_addr_q + 1'b1;
                rd_left_q <= rd_left_q - 1'b1;
                if (rd_left_q == '0) begin
                    rd_busy_q <= 1'b0;
                end
            end
            // write burst ends on the master's last flag
            if (axi_req_i.aw_valid && axi_rsp_o.aw_ready) begin
                wr_busy_q <= 1'b1;
                wr_addr_q <= axi_req_i.aw.addr[15:2];
            end else if (axi_req_i.w_valid && axi_rsp_o.w_ready) begin
                mem[wr_addr_q] <= axi_req_i.w.data;
                wr_addr_q <= wr_addr_q + 1'b1;
                if (axi_req_i.w.last) begin
                    wr_busy_q <= 1'b0;
                    b_pend_q  <= 1'b1;
                end
            end
            if (b_pend_q && axi_req_i.b_ready) begin
                b_pend_q <= 1'b0;
            end
        end
    end

endmodule

/* bench/dma_backend_props.sv */
// master port handshake and burst geometry assertions, bound into the backend
`timescale 1ns/1ps
`include "dma_config.svh"

module dma_backend_props (
    input logic                  clk_i,
    input logic                  rst_ni,
    input dma_pkg::dma_axi_req_t axi_req_o,
    input dma_pkg::dma_axi_rsp_t axi_rsp_i
);
    localparam int unsigned PAGE_BITS = $clog2(`DMA_PAGE_BYTES);

    // valid held with a stable payload until ready
    ar_stable: assert property (@(posedge clk_i) disable iff (rst_ni)
        axi_req_o.ar_valid && !axi_rsp_i.ar_ready |=> axi_req_o.ar_valid && $stable(axi_req_o.ar))
        else $error("ar dropped or changed before ready");
    aw_stable: assert property (@(posedge clk_i) disable iff (rst_ni)
        axi_req_o.aw_valid && !axi_rsp_i.aw_ready |=> axi_req_o.aw_valid && $stable(axi_req_o.aw))
        else $error("aw dropped or changed before ready");
    w_stable: assert property (@(posedge clk_i) disable iff (rst_ni)
        axi_req_o.w_valid && !axi_rsp_i.w_ready |=> axi_req_o.w_valid && $stable(axi_req_o.w))
        else $error("w dropped or changed before ready");

    // no burst crosses a page, beat count bounded
    ar_page: assert property (@(posedge clk_i) disable iff (rst_ni)
        axi_req_o.ar_valid |-> (32'(axi_req_o.ar.addr[PAGE_BITS-1:0])
        + (32'(axi_req_o.ar.len) + 1) * `DMA_DATA_BYTES <= `DMA_PAGE_BYTES)
        && (32'(axi_req_o.ar.len) < `DMA_MAX_BEATS))
        else $error("ar burst crosses a page or is too long");
    aw_page: assert property (@(posedge clk_i) disable iff (rst_ni)
        axi_req_o.aw_valid |-> (32'(axi_req_o.aw.addr[PAGE_BITS-1:0])
        + (32'(axi_req_o.aw.len) + 1) * `DMA_DATA_BYTES <= `DMA_PAGE_BYTES)
        && (32'(axi_req_o.aw.len) < `DMA_MAX_BEATS))
        else $error("aw burst crosses a page or is too long");

endmodule

bind dma_backend dma_backend_props props_i (
    .clk_i(clk_i), .rst_ni(rst_ni), .axi_req_o(axi_req_o), .axi_rsp_i(axi_rsp_i)
);

/* bench/dma_backend_tb.sv */
// dma backend testbench: file stimulus, burst monitor, memory compare, watchdog
`timescale 1ns/1ps

module dma_backend_tb;
    localparam int unsigned MEM_WORDS = 16384;
    localparam int unsigned MAX_REQS = 64;

    logic                  clk = 1'b0;
    logic                  rst_ni;
    dma_pkg::burst_req_t   burst_req;
    logic                  valid;
    logic                  ready;
    dma_pkg::dma_axi_req_t axi_req;
    dma_pkg::dma_axi_rsp_t axi_rsp;
    logic                  idle;
    logic                  complete;
    logic                  stall_en;
    logic                  hold_ar;

    logic [31:0]         stim [0:5*MAX_REQS];
    logic [31:0]         ref_mem [MEM_WORDS];
    dma_pkg::burst_req_t req_list [MAX_REQS];
    int unsigned         req_bursts [MAX_REQS];
    int unsigned         req_total;
    int unsigned         pulses;
    int unsigned         watchdog_cycles;
    // index 0 tracks ar, index 1 tracks aw
    logic [31:0]         cur_addr [2];
    logic [31:0]         left_bytes [2];
    int unsigned         burst_cnt [2];
    int unsigned         next_req [2];

    always #4 clk = ~clk;

    dma_backend dma_backend_i (
        .clk_i(clk), .rst_ni(rst_ni), .burst_req_i(burst_req), .valid_i(valid),
        .ready_o(ready), .axi_req_o(axi_req), .axi_rsp_i(axi_rsp),
        .backend_idle_o(idle), .trans_complete_o(complete)
    );

    dma_mem_model mem_i (
        .clk_i(clk), .rst_ni(rst_ni), .stall_en_i(stall_en), .hold_ar_i(hold_ar),
        .axi_req_i(axi_req), .axi_rsp_o(axi_rsp)
    );

    task automatic report_error(input string msg);
        $display("%s", msg);
        $display("Something failed");
        $fatal(1, "run stopped");
    endtask

    // --------------------------------------------------
    // burst monitor
    // --------------------------------------------------
    // bursts must tile each request in order
    task automatic track_burst(input int c, input logic [31:0] addr, input logic [3:0] len);
        logic [31:0] bytes;
        bytes = (32'(len) + 1) * 4;
        if (left_bytes[c] == '0) begin
            assert (next_req[c] < req_total) else report_error("burst issued with no request pending");
            cur_addr[c]   = (c == 0) ? req_list[next_req[c]].src : req_list[next_req[c]].dst;
            left_bytes[c] = req_list[next_req[c]].num_bytes;
            burst_cnt[c]  = 0;
        end
        assert (addr == cur_addr[c]) else report_error($sformatf(
            "Mismatch burst_address ch%0d expected %h actual %h", c, cur_addr[c], addr));
        assert (bytes <= left_bytes[c]) else report_error("burst runs past the end of its request");
        cur_addr[c]   = cur_addr[c] + bytes;
        left_bytes[c] = left_bytes[c] - bytes;
        burst_cnt[c]  = burst_cnt[c] + 1;
        if (left_bytes[c] == '0) begin
            assert (burst_cnt[c] == req_bursts[next_req[c]]) else report_error($sformatf(
                "Mismatch burst_count ch%0d expected %0d actual %0d",
                c, req_bursts[next_req[c]], burst_cnt[c]));
            next_req[c] = next_req[c] + 1;
        end
    endtask

    always @(negedge clk) begin
        if (!rst_ni) begin
            if (axi_req.ar_valid && axi_rsp.ar_ready) begin
                track_burst(0, axi_req.ar.addr, axi_req.ar.len);
            end
            if (axi_req.aw_valid && axi_rsp.aw_ready) begin
                track_burst(1, axi_req.aw.addr, axi_req.aw.len);
            end
            if (complete) begin
                // each pulse belongs to a request whose final aw is already out
                assert (pulses < next_req[1]) else report_error($sformatf(
                    "Mismatch pulse_count expected at most %0d actual %0d",
                    next_req[1], pulses + 1));
                pulses = pulses + 1;
            end
        end
    end

    // --------------------------------------------------
    // stimulus
    // --------------------------------------------------
    task automatic push_line(input int unsigned line);
        int unsigned base;
        logic        taken;
        base = 1 + 5 * line;
        @(posedge clk);
        #1;
        stall_en = (stim[base+4] == 1);
        if (stim[base+4] == 2) begin
            hold_ar = 1'b1;
        end
        burst_req.src       = stim[base];
        burst_req.dst       = stim[base+1];
        burst_req.num_bytes = stim[base+2];
        valid = 1'b1;
        taken = 1'b0;
        while (!taken) begin
            @(negedge clk);
            taken = ready;
            @(posedge clk);
            #1;
        end
        valid = 1'b0;
        // reference copy, word by word
        for (int unsigned w = 0; w < stim[base+2] / 4; w++) begin
            ref_mem[14'((stim[base+1] >> 2) + w)] = ref_mem[14'((stim[base] >> 2) + w)];
        end
        if (stim[base+2] != '0) begin
            req_list[req_total]   = burst_req;
            req_bursts[req_total] = stim[base+3];
            req_total = req_total + 1;
        end
    endtask

    initial begin
        int unsigned n_lines;
        int unsigned line;
        rst_ni    = 1'b1;
        valid     = 1'b0;
        burst_req = '0;
        stall_en  = 1'b0;
        hold_ar   = 1'b0;
        req_total = 0;
        pulses    = 0;
        for (int c = 0; c < 2; c++) begin
            left_bytes[c] = '0;
            next_req[c]   = 0;
        end
        $readmemh("bench/dma_stimulus.txt", stim);
        n_lines = stim[0];
        watchdog_cycles = 4000;
        for (int unsigned i = 0; i < n_lines; i++) begin
            watchdog_cycles = watchdog_cycles + stim[3+5*i] * 8;
        end
        #1;
        for (int unsigned w = 0; w < MEM_WORDS; w++) begin
            ref_mem[w] = mem_i.mem[w];
        end
        repeat (5) @(posedge clk);
        #1;
        rst_ni = 1'b0;
        @(negedge clk);
        assert (idle && ready && !complete && !axi_req.ar_valid && !axi_req.aw_valid
                && !axi_req.w_valid) else report_error("outputs not at their reset values");

        line = 0;
        while (line < n_lines) begin
            if (stim[5+5*line] == 2) begin
                // batch under held ar, request queue must fill
                while (line < n_lines && stim[5+5*line] == 2) begin
                    push_line(line);
                    line = line + 1;
                end
                repeat (20) @(negedge clk);
                assert (!ready) else report_error("request queue never filled while ar was held");
                @(posedge clk);
                #1;
                hold_ar = 1'b0;
            end else begin
                push_line(line);
                line = line + 1;
            end
            while (pulses != req_total) @(negedge clk);
            while (!idle) @(negedge clk);
        end

        assert (next_req[0] == req_total && next_req[1] == req_total)
            else report_error("not every request was covered by its bursts");
        for (int unsigned w = 0; w < MEM_WORDS; w++) begin
            assert (mem_i.mem[w] == ref_mem[w]) else report_error($sformatf(
                "Mismatch memory_word %h expected %h actual %h", w * 4, ref_mem[w], mem_i.mem[w]));
        end
        $display("Everything OK");
        $finish;
    end

    // watchdog, scaled by total bytes in the file
    initial begin
        wait (watchdog_cycles != 0);
        repeat (watchdog_cycles) @(posedge clk);
        report_error("watchdog timeout, transfers did not finish");
    end

endmodule

/* verilog.f */
+incdir+include
source/dma_pkg.sv
source/dma_queue.sv
source/dma_burst_reshaper.sv
source/dma_data_mover.sv
source/dma_backend.sv
bench/dma_mem_model.sv
bench/dma_backend_props.sv
bench/dma_backend_tb.sv

/* Makefile */
SIM := obj_dir/dma_sim
SOURCES := $(filter-out +%,$(shell cat verilog.f)) include/dma_config.svh

.PHONY: all run clean

all: $(SIM)

$(SIM): $(SOURCES) verilog.f
	verilator --binary --timing --assert -Wno-fatal -f verilog.f \
		--top-module dma_backend_tb -Mdir obj_dir -o dma_sim

run: $(SIM)
	@out=$$(./$(SIM)); echo "$$out"; echo "$$out" | grep -q "^Everything OK$$"

clean:
	rm -rf obj_dir

/* bench/dma_stimulus.txt */
// dma backend stimulus: first word is the request count, then one request per line
// columns (hex): source, destination, byte count, expected bursts, mode (0 plain, 1 stalls, 2 batch with ar held)
11
00000000 00008000 00000040 1 0
00000100 00009000 00000100 4 0
00000FF0 0000A000 00000020 2 0
00002000 0000AFF8 00000048 2 0
00003000 0000B000 00000000 0 0
00003004 0000B104 00000004 1 0
00004000 0000C000 000001F0 8 1
00004FC8 0000CFE0 00000088 4 1
00006000 0000E000 00000040 1 2
00006040 0000E040 00000040 1 2
00006080 0000E080 00000040 1 2
000060C0 0000E0C0 00000040 1 2
00006100 0000E100 00000040 1 2
00006140 0000E140 00000040 1 2
00006180 0000E180 00000040 1 2
000061C0 0000E1C0 00000040 1 2
00006200 0000E200 00000040 1 2
